// ==== Bender.yml ====
package:
  name: htable_stash_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/htable_pkg.sv
      - source/htable_intf.sv
      - source/htable_lookup_dispatch.sv
      - source/htable_table.sv
      - source/htable_stash.sv
      - source/htable_resp_merge.sv
      - source/htable_stash_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_htable_stash_core.sv

// ==== files.f ====
+incdir+source
source/htable_pkg.sv
source/htable_intf.sv
source/htable_lookup_dispatch.sv
source/htable_table.sv
source/htable_stash.sv
source/htable_resp_merge.sv
source/htable_stash_core.sv
tests/tb_htable_stash_core.sv

// ==== source/htable_defines.svh ====
`ifndef HTABLE_DEFINES_SVH
`define HTABLE_DEFINES_SVH

// Key and value widths
`define HTABLE_KEY_WID 16
`define HTABLE_VALUE_WID 16

// Table index width, depth is 2**HTABLE_INDEX_WID
`define HTABLE_INDEX_WID 4

// Overflow stash entries
`define HTABLE_STASH_SIZE 4

// Lookups accepted but not yet taken at the result port
`define HTABLE_MAX_INFLIGHT 4

`endif

// ==== source/htable_intf.sv ====
`timescale 1ns/10ps
`default_nettype none

// Lookup request and response bundle
interface htable_lookup_if ();
    import htable_pkg::*;

    logic   req;
    logic   rdy;
    key_t   key;
    // Response, one ack per accepted request, in order
    logic   ack;
    logic   found;
    value_t value;

    modport requester (
        output req,
        output key,
        input  rdy,
        input  ack,
        input  found,
        input  value
    );

    modport responder (
        input  req,
        input  key,
        output rdy,
        output ack,
        output found,
        output value
    );
endinterface : htable_lookup_if

// Control write bundle, always accepted by the sinks
interface htable_wr_if ();
    import htable_pkg::*;

    logic       wr;
    htable_op_t op;
    key_t       key;
    value_t     value;

    modport source (output wr, output op, output key, output value);
    modport sink   (input wr, input op, input key, input value);
endinterface : htable_wr_if

`default_nettype wire

// ==== source/htable_lookup_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module htable_lookup_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_done,
    // Lookup port
    input  logic                   lookup_valid,
    output logic                   lookup_ready,
    input  htable_pkg::key_t       lookup_key,
    // Result handshake, returns one credit
    input  logic                   result_taken,
    // Control port
    input  logic                   ctrl_valid,
    output logic                   ctrl_ready,
    input  htable_pkg::htable_op_t ctrl_op,
    input  htable_pkg::key_t       ctrl_key,
    input  htable_pkg::value_t     ctrl_value,
    // Toward the two stores
    htable_lookup_if.requester     tbl_lookup,
    htable_lookup_if.requester     stash_lookup,
    htable_wr_if.source            wr
);
    import htable_pkg::*;

    localparam int CRED_WID = $clog2(`HTABLE_MAX_INFLIGHT + 1);

    logic                lkp_vld;
    key_t                lkp_key;
    logic [CRED_WID-1:0] credits;
    logic                lookup_xfer;
    logic                ctrl_xfer;

    // ----------------------------
    // Handshakes
    // ----------------------------
    // Control only when nothing is in flight
    assign ctrl_ready = init_done && (credits == '0);
    assign ctrl_xfer  = ctrl_valid && ctrl_ready;

    // Control wins a same-cycle tie so a write never overlaps a lookup
    assign lookup_ready = init_done && (credits != CRED_WID'(`HTABLE_MAX_INFLIGHT))
                          && tbl_lookup.rdy && stash_lookup.rdy && !ctrl_xfer;
    assign lookup_xfer  = lookup_valid && lookup_ready;

    // Issue from the input register to both stores at once
    assign tbl_lookup.req   = lkp_vld;
    assign tbl_lookup.key   = lkp_key;
    assign stash_lookup.req = lkp_vld;
    assign stash_lookup.key = lkp_key;

    // ----------------------------
    // Registers
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            lkp_vld <= 1'b0;
            credits <= '0;
            wr.wr   <= 1'b0;
        end else begin
            lkp_vld <= lookup_xfer;
            // One-cycle write pulse
            wr.wr   <= ctrl_xfer;
            if (lookup_xfer && !result_taken) begin
                credits <= credits + 1'b1;
            end else if (!lookup_xfer && result_taken) begin
                credits <= credits - 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (lookup_xfer) begin
            lkp_key <= lookup_key;
        end
        if (ctrl_xfer) begin
            wr.op    <= ctrl_op;
            wr.key   <= ctrl_key;
            wr.value <= ctrl_value;
        end
    end

    // Credits bound what the merge queue has to hold
    a_credit_limit : assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_WID'(`HTABLE_MAX_INFLIGHT))
        else $error("credit count above in-flight limit");

endmodule : htable_lookup_dispatch

`default_nettype wire

// ==== source/htable_pkg.sv ====
`default_nettype none

`include "htable_defines.svh"

package htable_pkg;

    // Payload types
    typedef logic [`HTABLE_KEY_WID-1:0]   key_t;
    typedef logic [`HTABLE_VALUE_WID-1:0] value_t;
    typedef logic [`HTABLE_INDEX_WID-1:0] index_t;

    // Control port opcodes
    typedef enum logic [1:0] {
        OP_TBL_INSERT   = 2'd0,
        OP_TBL_DELETE   = 2'd1,
        OP_STASH_INSERT = 2'd2,
        OP_STASH_DELETE = 2'd3
    } htable_op_t;

    // Table init sequencing
    typedef enum logic {
        INIT_SWEEP = 1'b0,
        INIT_READY = 1'b1
    } htable_init_state_t;

endpackage : htable_pkg

`default_nettype wire

// ==== source/htable_resp_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module htable_resp_merge #(
    parameter int DEPTH = `HTABLE_MAX_INFLIGHT
) (
    input  logic               clk,
    input  logic               rst,
    // Response side of both stores
    htable_lookup_if.requester tbl_rsp,
    htable_lookup_if.requester stash_rsp,
    // Result port
    output logic               result_valid,
    input  logic               result_ready,
    output logic               result_found,
    output htable_pkg::value_t result_value
);
    import htable_pkg::*;

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    function automatic logic [PTR_WID-1:0] ptr_next(input logic [PTR_WID-1:0] p);
        return (p == PTR_WID'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Stash answers waiting for the table
    logic               ctx_found [DEPTH];
    value_t             ctx_value [DEPTH];
    logic [PTR_WID-1:0] ctx_wr_ptr;
    logic [PTR_WID-1:0] ctx_rd_ptr;
    logic [CNT_WID-1:0] ctx_cnt;

    // Merged results
    logic               out_found [DEPTH];
    value_t             out_value [DEPTH];
    logic [PTR_WID-1:0] out_wr_ptr;
    logic [PTR_WID-1:0] out_rd_ptr;
    logic [CNT_WID-1:0] out_cnt;
    logic               out_push;
    logic               out_pop;

    logic   mrg_found;
    value_t mrg_value;

    // ----------------------------
    // Context queue
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctx_wr_ptr <= '0;
            ctx_rd_ptr <= '0;
            ctx_cnt    <= '0;
        end else begin
            if (stash_rsp.ack) begin
                ctx_wr_ptr <= ptr_next(ctx_wr_ptr);
            end
            if (tbl_rsp.ack) begin
                ctx_rd_ptr <= ptr_next(ctx_rd_ptr);
            end
            ctx_cnt <= ctx_cnt + CNT_WID'(stash_rsp.ack) - CNT_WID'(tbl_rsp.ack);
        end
    end

    always_ff @(posedge clk) begin
        if (stash_rsp.ack) begin
            ctx_found[ctx_wr_ptr] <= stash_rsp.found;
            ctx_value[ctx_wr_ptr] <= stash_rsp.value;
        end
    end

    // Stash hit first, then table hit, else a clean miss
    always_comb begin
        mrg_found = ctx_found[ctx_rd_ptr] || tbl_rsp.found;
        if (ctx_found[ctx_rd_ptr]) begin
            mrg_value = ctx_value[ctx_rd_ptr];
        end else if (tbl_rsp.found) begin
            mrg_value = tbl_rsp.value;
        end else begin
            mrg_value = '0;
        end
    end

    // ----------------------------
    // Output queue
    // ----------------------------
    assign out_push = tbl_rsp.ack;
    assign out_pop  = result_valid && result_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_wr_ptr <= '0;
            out_rd_ptr <= '0;
            out_cnt    <= '0;
        end else begin
            if (out_push) begin
                out_wr_ptr <= ptr_next(out_wr_ptr);
            end
            if (out_pop) begin
                out_rd_ptr <= ptr_next(out_rd_ptr);
            end
            out_cnt <= out_cnt + CNT_WID'(out_push) - CNT_WID'(out_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (out_push) begin
            out_found[out_wr_ptr] <= mrg_found;
            out_value[out_wr_ptr] <= mrg_value;
        end
    end

    assign result_valid = (out_cnt != '0);
    assign result_found = out_found[out_rd_ptr];
    assign result_value = out_value[out_rd_ptr];

    // Stash always answers a cycle ahead of the table
    a_ctx_no_uflow : assert property (@(posedge clk) disable iff (rst)
        tbl_rsp.ack |-> (ctx_cnt != '0))
        else $error("table answer without a queued stash answer");

    // Dispatch credits keep the queue from filling past DEPTH
    a_out_no_oflow : assert property (@(posedge clk) disable iff (rst)
        (out_push && !out_pop) |-> (out_cnt != CNT_WID'(DEPTH)))
        else $error("result queue overflow");

endmodule : htable_resp_merge

`default_nettype wire

// ==== source/htable_stash.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module htable_stash #(
    parameter int SIZE = `HTABLE_STASH_SIZE
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic [$clog2(SIZE+1)-1:0] count,
    htable_lookup_if.responder        lookup,
    htable_wr_if.sink                 wr
);
    import htable_pkg::*;

    localparam int IDX_WID = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int CNT_WID = $clog2(SIZE + 1);

    // Slot storage
    logic [SIZE-1:0] slot_vld;
    key_t            slot_key [SIZE];
    value_t          slot_val [SIZE];

    logic [SIZE-1:0]    wr_hit;
    logic [IDX_WID-1:0] hit_idx;
    logic [IDX_WID-1:0] free_idx;
    logic               have_free;
    logic [SIZE-1:0]    lk_hit;
    value_t             lk_value;
    logic               dup_key;

    // ----------------------------
    // Slot match and free search
    // ----------------------------
    always_comb begin
        wr_hit    = '0;
        lk_hit    = '0;
        hit_idx   = '0;
        free_idx  = '0;
        have_free = 1'b0;
        lk_value  = '0;
        // Walk downwards so the lowest free slot is left last
        for (int i = SIZE - 1; i >= 0; i--) begin
            wr_hit[i] = slot_vld[i] && (slot_key[i] == wr.key);
            lk_hit[i] = slot_vld[i] && (slot_key[i] == lookup.key);
            if (wr_hit[i]) begin
                hit_idx = IDX_WID'(i);
            end
            if (!slot_vld[i]) begin
                free_idx  = IDX_WID'(i);
                have_free = 1'b1;
            end
            if (lk_hit[i]) begin
                lk_value = slot_val[i];
            end
        end
    end

    // Occupancy and duplicate check
    always_comb begin
        count   = '0;
        dup_key = 1'b0;
        for (int i = 0; i < SIZE; i++) begin
            count = count + CNT_WID'(slot_vld[i]);
            for (int j = 0; j < i; j++) begin
                if (slot_vld[i] && slot_vld[j] && slot_key[i] == slot_key[j]) begin
                    dup_key = 1'b1;
                end
            end
        end
    end

    // ----------------------------
    // Control writes
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_vld <= '0;
        end else if (wr.wr) begin
            // Same-key insert keeps its slot, full stash drops the insert
            if (wr.op == OP_STASH_INSERT && wr_hit == '0 && have_free) begin
                slot_vld[free_idx] <= 1'b1;
            end else if (wr.op == OP_STASH_DELETE) begin
                slot_vld <= slot_vld & ~wr_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr && wr.op == OP_STASH_INSERT) begin
            if (wr_hit != '0) begin
                slot_val[hit_idx] <= wr.value;
            end else if (have_free) begin
                slot_key[free_idx] <= wr.key;
                slot_val[free_idx] <= wr.value;
            end
        end
    end

    // ----------------------------
    // Lookup, one cycle
    // ----------------------------
    // Single-cycle compare, never stalls
    assign lookup.rdy = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup.ack <= 1'b0;
        end else begin
            lookup.ack <= lookup.req;
        end
    end

    always_ff @(posedge clk) begin
        lookup.found <= (lk_hit != '0);
        lookup.value <= lk_value;
    end

    // Inserts of a present key must reuse its slot
    a_unique_keys : assert property (@(posedge clk) disable iff (rst) !dup_key)
        else $error("two stash slots hold the same key");

endmodule : htable_stash

`default_nettype wire

// ==== source/htable_stash_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module htable_stash_core (
    input  logic                                       clk,
    input  logic                                       rst,
    // Lookup port
    input  logic                                       lookup_valid,
    output logic                                       lookup_ready,
    input  htable_pkg::key_t                           lookup_key,
    // Result port
    output logic                                       result_valid,
    input  logic                                       result_ready,
    output logic                                       result_found,
    output htable_pkg::value_t                         result_value,
    // Control port
    input  logic                                       ctrl_valid,
    output logic                                       ctrl_ready,
    input  htable_pkg::htable_op_t                     ctrl_op,
    input  htable_pkg::key_t                           ctrl_key,
    input  htable_pkg::value_t                         ctrl_value,
    // Status
    output logic                                       init_done,
    output logic [$clog2(`HTABLE_STASH_SIZE + 1)-1:0] stash_count
);
    logic result_taken;

    // ----------------------------
    // Internal bundles
    // ----------------------------
    htable_lookup_if tbl_lookup_if ();
    htable_lookup_if stash_lookup_if ();
    htable_wr_if     wr_if ();

    // Each result handshake frees one credit
    assign result_taken = result_valid && result_ready;

    // Input side
    htable_lookup_dispatch i_htable_lookup_dispatch (
        .clk          ( clk ),
        .rst          ( rst ),
        .init_done    ( init_done ),
        .lookup_valid ( lookup_valid ),
        .lookup_ready ( lookup_ready ),
        .lookup_key   ( lookup_key ),
        .result_taken ( result_taken ),
        .ctrl_valid   ( ctrl_valid ),
        .ctrl_ready   ( ctrl_ready ),
        .ctrl_op      ( ctrl_op ),
        .ctrl_key     ( ctrl_key ),
        .ctrl_value   ( ctrl_value ),
        .tbl_lookup   ( tbl_lookup_if ),
        .stash_lookup ( stash_lookup_if ),
        .wr           ( wr_if )
    );

    // Direct-mapped table, two-cycle answer
    htable_table i_htable_table (
        .clk       ( clk ),
        .rst       ( rst ),
        .init_done ( init_done ),
        .lookup    ( tbl_lookup_if ),
        .wr        ( wr_if )
    );

    // Overflow stash, one-cycle answer
    htable_stash #(
        .SIZE   ( `HTABLE_STASH_SIZE )
    ) i_htable_stash (
        .clk    ( clk ),
        .rst    ( rst ),
        .count  ( stash_count ),
        .lookup ( stash_lookup_if ),
        .wr     ( wr_if )
    );

    // Output side
    htable_resp_merge #(
        .DEPTH        ( `HTABLE_MAX_INFLIGHT )
    ) i_htable_resp_merge (
        .clk          ( clk ),
        .rst          ( rst ),
        .tbl_rsp      ( tbl_lookup_if ),
        .stash_rsp    ( stash_lookup_if ),
        .result_valid ( result_valid ),
        .result_ready ( result_ready ),
        .result_found ( result_found ),
        .result_value ( result_value )
    );

endmodule : htable_stash_core

`default_nettype wire

// ==== source/htable_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module htable_table (
    input  logic               clk,
    input  logic               rst,
    output logic               init_done,
    htable_lookup_if.responder lookup,
    htable_wr_if.sink          wr
);
    import htable_pkg::*;

    localparam int DEPTH   = 1 << `HTABLE_INDEX_WID;
    localparam int NIBBLES = `HTABLE_KEY_WID / `HTABLE_INDEX_WID;

    // Index is the xor of all index-wide slices of the key
    function automatic index_t hash_fold(input key_t k);
        index_t h;
        h = '0;
        for (int i = 0; i < NIBBLES; i++) begin
            h ^= k[i*`HTABLE_INDEX_WID +: `HTABLE_INDEX_WID];
        end
        return h;
    endfunction

    htable_init_state_t state;
    index_t             sweep_idx;

    // Entry storage
    logic   ent_vld [DEPTH];
    key_t   ent_key [DEPTH];
    value_t ent_val [DEPTH];

    index_t wr_idx;
    index_t rd_idx;
    logic   wr_match;

    // Lookup stage 1
    logic   s1_req;
    key_t   s1_key;
    logic   s1_vld;
    key_t   s1_ent_key;
    value_t s1_ent_val;
    logic   s1_hit;

    // ----------------------------
    // Init sweep
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= INIT_SWEEP;
            sweep_idx <= '0;
        end else if (state == INIT_SWEEP) begin
            sweep_idx <= sweep_idx + 1'b1;
            // Last entry cleared, table usable
            if (sweep_idx == index_t'(DEPTH - 1)) begin
                state <= INIT_READY;
            end
        end
    end

    assign init_done  = (state == INIT_READY);
    assign lookup.rdy = init_done;

    // ----------------------------
    // Control writes
    // ----------------------------
    assign wr_idx   = hash_fold(wr.key);
    assign wr_match = ent_vld[wr_idx] && (ent_key[wr_idx] == wr.key);

    // Valid bits are cleared by the sweep
    always_ff @(posedge clk) begin
        if (state == INIT_SWEEP) begin
            ent_vld[sweep_idx] <= 1'b0;
        end else if (wr.wr && wr.op == OP_TBL_INSERT) begin
            ent_vld[wr_idx] <= 1'b1;
        end else if (wr.wr && wr.op == OP_TBL_DELETE && wr_match) begin
            // Delete only the key that actually lives here
            ent_vld[wr_idx] <= 1'b0;
        end
    end

    // Insert overwrites whatever held the slot
    always_ff @(posedge clk) begin
        if (wr.wr && wr.op == OP_TBL_INSERT) begin
            ent_key[wr_idx] <= wr.key;
            ent_val[wr_idx] <= wr.value;
        end
    end

    // ----------------------------
    // Lookup pipeline
    // ----------------------------
    assign rd_idx = hash_fold(lookup.key);
    assign s1_hit = s1_vld && (s1_ent_key == s1_key);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_req     <= 1'b0;
            lookup.ack <= 1'b0;
        end else begin
            s1_req     <= lookup.req;
            lookup.ack <= s1_req;
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1, read the entry
        s1_key     <= lookup.key;
        s1_vld     <= ent_vld[rd_idx];
        s1_ent_key <= ent_key[rd_idx];
        s1_ent_val <= ent_val[rd_idx];
        // Stage 2, compare and answer
        lookup.found <= s1_hit;
        lookup.value <= s1_hit ? s1_ent_val : '0;
    end

    // Dispatch must hold lookups until the sweep is over
    a_no_early_lookup : assert property (@(posedge clk) disable iff (rst)
        lookup.req |-> init_done)
        else $error("lookup issued before table init");

endmodule : htable_table

`default_nettype wire

// ==== tests/htable_patterns.txt ====
# C op key value     control write (op 0 tbl insert, 1 tbl delete, 2 stash insert, 3 stash delete)
# L key found value  lookup with its expected found flag and value
# N count            expected stash occupancy
L 1234 0 0000
L 4000 0 0000
N 0
C 0 1234 aaaa
C 0 0005 bbbb
L 1234 1 aaaa
L 0005 1 bbbb
C 0 4000 cccc
L 1234 0 0000
L 4000 1 cccc
C 2 1234 1111
L 1234 1 1111
C 2 0005 2222
L 0005 1 2222
C 2 00ab 3333
C 2 0001 4444
N 4
C 2 0002 5555
N 4
L 0002 0 0000
C 3 0005 0000
L 0005 1 bbbb
N 3
C 1 0014 0000
L 0005 1 bbbb
C 1 0005 0000
L 0005 0 0000
C 3 1234 0000
L 1234 0 0000
N 2
L 4000 1 cccc
L 00ab 1 3333
L 0001 1 4444
L 0005 0 0000
L 7777 0 0000
L 4000 1 cccc
L 1234 0 0000
L 00ab 1 3333
L 0001 1 4444
L 4000 1 cccc
L 0002 0 0000
L 0001 1 4444

// ==== tests/tb_htable_stash_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "htable_defines.svh"

module tb_htable_stash_core;
    import htable_pkg::*;

    localparam int CNT_WID   = $clog2(`HTABLE_STASH_SIZE + 1);
    localparam int SWEEP_CYC = 1 << `HTABLE_INDEX_WID;
    localparam int LINE_CYC  = 40;

    typedef logic [CNT_WID-1:0] count_t;

    logic       clk;
    logic       rst;
    logic       lookup_valid;
    logic       lookup_ready;
    key_t       lookup_key;
    logic       result_valid;
    logic       result_ready;
    logic       result_found;
    value_t     result_value;
    logic       ctrl_valid;
    logic       ctrl_ready;
    htable_op_t ctrl_op;
    key_t       ctrl_key;
    value_t     ctrl_value;
    logic       init_done;
    count_t     stash_count;

    // Parsed pattern lines and their tag characters
    logic [7:0]  pat_kind [$];
    logic [31:0] pat_a [$];
    logic [31:0] pat_b [$];
    logic [31:0] pat_c [$];
    logic        loaded = 1'b0;

    // Expected results in request order
    logic   exp_found_q [$];
    value_t exp_value_q [$];

    integer seed = 32'hce60_b38c;

    htable_stash_core i_dut (
        .clk          ( clk ),
        .rst          ( rst ),
        .lookup_valid ( lookup_valid ),
        .lookup_ready ( lookup_ready ),
        .lookup_key   ( lookup_key ),
        .result_valid ( result_valid ),
        .result_ready ( result_ready ),
        .result_found ( result_found ),
        .result_value ( result_value ),
        .ctrl_valid   ( ctrl_valid ),
        .ctrl_ready   ( ctrl_ready ),
        .ctrl_op      ( ctrl_op ),
        .ctrl_key     ( ctrl_key ),
        .ctrl_value   ( ctrl_value ),
        .init_done    ( init_done ),
        .stash_count  ( stash_count )
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------
    // Failure and compare tasks
    // ----------------------------
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_found(input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch result_found: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_value(input value_t got, input value_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch result_value: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_count(input count_t got, input count_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch stash_count: got %h expected %h", got, exp));
        end
    endtask

    // ----------------------------
    // Pattern file
    // ----------------------------
    task automatic load_patterns;
        integer           fd;
        integer           code;
        logic [8*8-1:0]   tag;
        logic [8*120-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        fd = $fopen("tests/htable_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open tests/htable_patterns.txt");
        end
        while (!$feof(fd)) begin
            tag  = '0;
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                a = '0;
                b = '0;
                c = '0;
                if (tag == "#") begin
                    // Drop the rest of a comment line
                    code = $fgets(rest, fd);
                end else if (tag == "C" || tag == "L") begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    if (code != 3) begin
                        stop_with_failure("Pattern line with missing fields");
                    end
                end else if (tag == "N") begin
                    code = $fscanf(fd, "%h", a);
                    if (code != 1) begin
                        stop_with_failure("Count line without a value");
                    end
                end else begin
                    stop_with_failure($sformatf("Unknown pattern tag %0s", tag));
                end
                if (tag != "#") begin
                    pat_kind.push_back(tag[7:0]);
                    pat_a.push_back(a);
                    pat_b.push_back(b);
                    pat_c.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------
    // Port drivers
    // ----------------------------
    // Called 1 ns after an edge with ready sampled mid-cycle
    task automatic send_ctrl(input htable_op_t op, input key_t key, input value_t value);
        logic taken;
        ctrl_valid = 1'b1;
        ctrl_op    = op;
        ctrl_key   = key;
        ctrl_value = value;
        taken      = 1'b0;
        while (!taken) begin
            #1;
            taken = ctrl_ready;
            @(posedge clk);
            #1;
        end
        ctrl_valid = 1'b0;
    endtask

    task automatic send_lookup(input key_t key, input logic found, input value_t value);
        logic taken;
        lookup_valid = 1'b1;
        lookup_key   = key;
        taken        = 1'b0;
        while (!taken) begin
            #1;
            taken = lookup_ready;
            @(posedge clk);
            #1;
        end
        lookup_valid = 1'b0;
        exp_found_q.push_back(found);
        exp_value_q.push_back(value);
        // Outstanding count as seen at the ports
        if (exp_found_q.size() > `HTABLE_MAX_INFLIGHT) begin
            stop_with_failure("More lookups outstanding than the in-flight limit allows");
        end
    endtask

    // Wait for all results and let the last write settle
    task automatic verify_stash_count(input count_t exp);
        while (exp_found_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        check_count(stash_count, exp);
    endtask

    // ----------------------------
    // Result side with back-pressure
    // ----------------------------
    initial begin
        logic [31:0] rnd;
        wait (loaded && rst === 1'b0);
        forever begin
            @(posedge clk);
            #1;
            rnd          = $random(seed);
            result_ready = (rnd[1:0] != 2'b00);
            #1;
            if (result_valid === 1'b1 && result_ready) begin
                if (exp_found_q.size() == 0) begin
                    stop_with_failure("Result appeared with no lookup outstanding");
                end
                check_found(result_found, exp_found_q.pop_front());
                check_value(result_value, exp_value_q.pop_front());
            end
        end
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (loaded);
        repeat (pat_kind.size() * LINE_CYC + SWEEP_CYC + 4) @(posedge clk);
        stop_with_failure("Timeout while waiting for the DUT to finish the patterns");
    end

    // ----------------------------
    // Main sequence
    // ----------------------------
    initial begin
        int cycles;
        rst          = 1'b1;
        lookup_valid = 1'b0;
        lookup_key   = '0;
        result_ready = 1'b0;
        ctrl_valid   = 1'b0;
        ctrl_op      = OP_TBL_INSERT;
        ctrl_key     = '0;
        ctrl_value   = '0;
        load_patterns();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        if (init_done !== 1'b0 || lookup_ready !== 1'b0 || ctrl_ready !== 1'b0
            || result_valid !== 1'b0) begin
            stop_with_failure("Handshake or status outputs not low after reset");
        end

        // Sweep clears one entry per cycle
        cycles = 0;
        while (init_done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cycles != SWEEP_CYC) begin
            stop_with_failure($sformatf("Table init took %0d cycles instead of %0d",
                                        cycles, SWEEP_CYC));
        end

        for (int i = 0; i < pat_kind.size(); i++) begin
            case (pat_kind[i])
                "C": send_ctrl(htable_op_t'(pat_a[i][1:0]), key_t'(pat_b[i]),
                               value_t'(pat_c[i]));
                "L": send_lookup(key_t'(pat_a[i]), pat_b[i][0], value_t'(pat_c[i]));
                default: verify_stash_count(count_t'(pat_a[i]));
            endcase
        end

        // Drain and make sure nothing else comes out
        while (exp_found_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
        if (result_valid === 1'b0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("Result port still busy after all lookups were answered");
        end
    end

endmodule : tb_htable_stash_core

`default_nettype wire
